// ==== Makefile ====
VERILATOR ?= verilator
TOP       := bbc_rom_boot_tb
FLIST     := bbc_rom_boot.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard rtl/*.sv dv/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== bbc_rom_boot.f ====
rtl/bbc_rom_boot_pkg.sv
rtl/flash_loader.sv
rtl/boot_control.sv
rtl/main_ram.sv
rtl/bbc_rom_boot.sv
dv/spi_flash_model.sv
dv/bbc_rom_boot_tb.sv

// ==== dv/bbc_rom_boot_tb.sv ====
`timescale 1ns/100ps

module bbc_rom_boot_tb;

	// sck rising edges in the whole read, header plus data
	localparam int TOTAL_RISES = 32 + bbc_rom_boot_pkg::LOAD_BYTES * 8;
	localparam int MAX_CYCLES  = 540000;

	logic clk_32m;
	logic rst_i;
	logic flash_miso_i;
	bbc_rom_boot_pkg::cpu_adr_t core_adr_i;
	logic core_we_i;
	bbc_rom_boot_pkg::byte_t core_dat_i;
	bbc_rom_boot_pkg::vid_adr_t vid_adr_i;
	logic flash_cs_o;
	logic flash_sck_o;
	logic flash_mosi_o;
	bbc_rom_boot_pkg::byte_t core_dat_o;
	logic core_rst_o;
	logic load_done_o;
	bbc_rom_boot_pkg::byte_t vid_dat_o;
	logic hdr_err;

	integer seed;
	// 2-state counters, start at zero
	int cyc;
	int rise_cnt;
	int after_last;
	string test_name;

	// read checks, set with the address, checked one cycle later
	logic core_chk_d;
	logic core_chk_q;
	logic [7:0] core_exp_d;
	logic [7:0] core_exp_q;
	logic vid_chk_d;
	logic vid_chk_q;
	logic [7:0] vid_exp_d;
	logic [7:0] vid_exp_q;

	// lower ram scoreboard
	logic [7:0] sb [32768];
	bit sb_valid [32768];
	logic [14:0] wr_q [$];

	bbc_rom_boot bbc_rom_boot_i (
		.clk_32m      (clk_32m),
		.rst_i        (rst_i),
		.flash_miso_i (flash_miso_i),
		.core_adr_i   (core_adr_i),
		.core_we_i    (core_we_i),
		.core_dat_i   (core_dat_i),
		.vid_adr_i    (vid_adr_i),
		.flash_cs_o   (flash_cs_o),
		.flash_sck_o  (flash_sck_o),
		.flash_mosi_o (flash_mosi_o),
		.core_dat_o   (core_dat_o),
		.core_rst_o   (core_rst_o),
		.load_done_o  (load_done_o),
		.vid_dat_o    (vid_dat_o)
	);

	spi_flash_model spi_flash_model_i (
		.cs_i      (flash_cs_o),
		.sck_i     (flash_sck_o),
		.mosi_i    (flash_mosi_o),
		.miso_o    (flash_miso_i),
		.hdr_err_o (hdr_err)
	);

	initial begin
		clk_32m = 1'b0;
		forever #2 clk_32m = ~clk_32m;
	end

	// expected rom byte for a ram address in the upper half
	function automatic logic [7:0] image_byte(input logic [15:0] ram_adr);
		logic [23:0] fa;
		fa = bbc_rom_boot_pkg::FLASH_BASE + {8'd0, ram_adr - bbc_rom_boot_pkg::ROM_BASE};
		return fa[7:0] ^ fa[15:8];
	endfunction

	task automatic report_mismatch(input string name, input logic [7:0] exp_v,
		input logic [7:0] act_v);
		$display("CHECKS FAILED");
		$display("Fail %s expected %h actual %h", name, exp_v, act_v);
		$fatal(1, "value mismatch");
	endtask

	task automatic report_error(input string what);
		$display("CHECKS FAILED");
		$display("%s", what);
		$fatal(1, "check failed");
	endtask

	// let the last pending read check fire before the next test starts
	task automatic drain_reads;
		@(negedge clk_32m);
		core_chk_d = 1'b0;
		vid_chk_d  = 1'b0;
		@(negedge clk_32m);
	endtask

	always @(posedge flash_sck_o) begin
		rise_cnt = rise_cnt + 1;
	end

	always @(posedge clk_32m) begin
		core_chk_q <= core_chk_d;
		core_exp_q <= core_exp_d;
		vid_chk_q  <= vid_chk_d;
		vid_exp_q  <= vid_exp_d;
		// cycles since the last sck rise was seen, saturating
		if ((rise_cnt == TOTAL_RISES) && (after_last < 3)) begin
			after_last <= after_last + 1;
		end
		cyc <= cyc + 1;
		if (cyc >= MAX_CYCLES) begin
			$display("CHECKS FAILED");
			$display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
			$fatal(1, "timeout");
		end
	end

	a_reset: assert property (@(posedge clk_32m)
		rst_i |=> (flash_cs_o && core_rst_o && !flash_sck_o && !load_done_o))
		else report_error("outputs not at reset values during reset");
	a_cs_fall: assert property (@(posedge clk_32m) $fell(rst_i) |=> !flash_cs_o)
		else report_error("flash_cs_o did not fall one cycle after reset");
	a_cs_low: assert property (@(posedge clk_32m) disable iff (rst_i)
		(!flash_cs_o && (rise_cnt < TOTAL_RISES)) |=> !flash_cs_o)
		else report_error("flash_cs_o rose before the transaction ended");
	a_hdr: assert property (@(posedge clk_32m) !hdr_err)
		else report_error("flash saw a wrong read command or start address");
	a_rise_max: assert property (@(posedge clk_32m) rise_cnt <= TOTAL_RISES)
		else report_error("too many sck edges in the flash transaction");
	a_held: assert property (@(posedge clk_32m) disable iff (rst_i)
		(after_last < 3) |-> (core_rst_o && !load_done_o))
		else report_error("core released before the image was complete");
	a_cs_end: assert property (@(posedge clk_32m) (after_last >= 2) |-> flash_cs_o)
		else report_error("flash_cs_o not high after the last byte");
	a_done: assert property (@(posedge clk_32m)
		(after_last >= 3) |-> (load_done_o && !core_rst_o))
		else report_error("load_done_o or core_rst_o wrong after the load");
	a_core_rd: assert property (@(posedge clk_32m) core_chk_q |-> (core_dat_o == core_exp_q))
		else report_mismatch(test_name, $sampled(core_exp_q), $sampled(core_dat_o));
	a_vid_rd: assert property (@(posedge clk_32m) vid_chk_q |-> (vid_dat_o == vid_exp_q))
		else report_mismatch(test_name, $sampled(vid_exp_q), $sampled(vid_dat_o));

	initial begin
		logic [31:0] rnd;
		logic [15:0] a;
		int idx;
		seed       = 86;
		rst_i      = 1'b1;
		core_adr_i = 16'd0;
		core_we_i  = 1'b0;
		core_dat_i = 8'd0;
		vid_adr_i  = 15'd0;
		core_chk_d = 1'b0;
		core_exp_d = 8'd0;
		vid_chk_d  = 1'b0;
		vid_exp_d  = 8'd0;
		test_name  = "load";
		repeat (5) @(posedge clk_32m);
		@(negedge clk_32m);
		rst_i = 1'b0;

		// core writes during the load, all must be dropped
		while (1) begin
			@(negedge clk_32m);
			if (load_done_o) break;
			rnd        = $random(seed);
			core_we_i  = 1'b1;
			core_adr_i = rnd[15:0];
			core_dat_i = rnd[23:16];
		end
		core_we_i = 1'b0;

		test_name = "rom_image";
		repeat (256) begin
			@(negedge clk_32m);
			rnd        = $random(seed);
			a          = {1'b1, rnd[14:0]};
			core_adr_i = a;
			core_exp_d = image_byte(a);
			core_chk_d = 1'b1;
		end
		drain_reads();

		test_name = "rom_protect";
		repeat (256) begin
			@(negedge clk_32m);
			rnd        = $random(seed);
			a          = {1'b1, rnd[14:0]};
			core_chk_d = 1'b0;
			core_we_i  = 1'b1;
			core_adr_i = a;
			core_dat_i = rnd[22:15];
			@(negedge clk_32m);
			core_we_i  = 1'b0;
			core_exp_d = image_byte(a);
			core_chk_d = 1'b1;
		end
		drain_reads();

		test_name = "lower_ram";
		repeat (256) begin
			@(negedge clk_32m);
			rnd        = $random(seed);
			core_chk_d = 1'b0;
			core_we_i  = 1'b1;
			core_adr_i = {1'b0, rnd[14:0]};
			core_dat_i = rnd[22:15];
			sb[rnd[14:0]]       = rnd[22:15];
			sb_valid[rnd[14:0]] = 1'b1;
			wr_q.push_back(rnd[14:0]);
		end
		repeat (256) begin
			@(negedge clk_32m);
			rnd        = $random(seed);
			idx        = int'(rnd[15:0]) % wr_q.size();
			core_we_i  = 1'b0;
			core_adr_i = {1'b0, wr_q[idx]};
			core_exp_d = sb[wr_q[idx]];
			core_chk_d = 1'b1;
		end
		drain_reads();

		// video reads, core writes unrelated lower addresses alongside
		test_name = "video";
		repeat (256) begin
			@(negedge clk_32m);
			core_chk_d = 1'b0;
			rnd        = $random(seed);
			idx        = int'(rnd[15:0]) % wr_q.size();
			vid_adr_i  = wr_q[idx];
			vid_exp_d  = sb[wr_q[idx]];
			vid_chk_d  = 1'b1;
			rnd        = $random(seed);
			core_we_i  = !sb_valid[rnd[14:0]];
			core_adr_i = {1'b0, rnd[14:0]};
			core_dat_i = rnd[22:15];
		end
		@(negedge clk_32m);
		core_we_i = 1'b0;
		vid_chk_d = 1'b0;
		repeat (3) @(posedge clk_32m);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== dv/spi_flash_model.sv ====
`timescale 1ns/100ps

module spi_flash_model (
	input  logic cs_i,
	input  logic sck_i,
	input  logic mosi_i,
	output logic miso_o,
	output logic hdr_err_o
);

	// command byte then 24 address bits
	logic [31:0] hdr;
	logic [23:0] adr;
	logic [7:0]  cur_byte;
	int          bit_idx;

	// image content, low address byte xor middle address byte
	function automatic logic [7:0] flash_byte(input logic [23:0] a);
		return a[7:0] ^ a[15:8];
	endfunction

	initial begin
		miso_o    = 1'b0;
		hdr_err_o = 1'b0;
		hdr       = 32'd0;
	end

	always begin
		@(negedge cs_i);
		// header shifted in on sck rising edges
		repeat (32) begin
			@(posedge sck_i);
			hdr = {hdr[30:0], mosi_i};
		end
		if ((hdr[31:24] != bbc_rom_boot_pkg::FLASH_READ_CMD) ||
			(hdr[23:0] != bbc_rom_boot_pkg::FLASH_BASE)) begin
			hdr_err_o = 1'b1;
		end
		adr     = hdr[23:0];
		bit_idx = 7;
		// data out on falling edges, msb first, until deselect
		while (!cs_i) begin
			@(negedge sck_i or posedge cs_i);
			if (!cs_i) begin
				cur_byte = flash_byte(adr);
				miso_o   = cur_byte[bit_idx];
				if (bit_idx == 0) begin
					bit_idx = 7;
					adr     = adr + 24'd1;
				end else begin
					bit_idx = bit_idx - 1;
				end
			end
		end
	end

endmodule

// ==== rtl/bbc_rom_boot.sv ====
`timescale 1ns/100ps

module bbc_rom_boot (
	input  logic                       clk_32m,
	input  logic                       rst_i,
	input  logic                       flash_miso_i,
	input  bbc_rom_boot_pkg::cpu_adr_t core_adr_i,
	input  logic                       core_we_i,
	input  bbc_rom_boot_pkg::byte_t    core_dat_i,
	input  bbc_rom_boot_pkg::vid_adr_t vid_adr_i,
	output logic                       flash_cs_o,
	output logic                       flash_sck_o,
	output logic                       flash_mosi_o,
	output bbc_rom_boot_pkg::byte_t    core_dat_o,
	output logic                       core_rst_o,
	output logic                       load_done_o,
	output bbc_rom_boot_pkg::byte_t    vid_dat_o
);

	// loader write stream
	logic                       ld_active;
	logic                       ld_we;
	bbc_rom_boot_pkg::cpu_adr_t ld_adr;
	bbc_rom_boot_pkg::byte_t    ld_dat;

	// ram port a after the owner mux
	logic                       ram_we;
	bbc_rom_boot_pkg::cpu_adr_t ram_adr;
	bbc_rom_boot_pkg::byte_t    ram_wdat;
	bbc_rom_boot_pkg::byte_t    ram_rdat;

	flash_loader flash_loader_i (
		.clk_32m      (clk_32m),
		.rst_i        (rst_i),
		.flash_miso_i (flash_miso_i),
		.flash_cs_o   (flash_cs_o),
		.flash_sck_o  (flash_sck_o),
		.flash_mosi_o (flash_mosi_o),
		.ld_active_o  (ld_active),
		.ld_we_o      (ld_we),
		.ld_adr_o     (ld_adr),
		.ld_dat_o     (ld_dat)
	);

	boot_control boot_control_i (
		.clk_32m     (clk_32m),
		.rst_i       (rst_i),
		.ld_active_i (ld_active),
		.ld_we_i     (ld_we),
		.ld_adr_i    (ld_adr),
		.ld_dat_i    (ld_dat),
		.core_adr_i  (core_adr_i),
		.core_we_i   (core_we_i),
		.core_dat_i  (core_dat_i),
		.ram_rdat_i  (ram_rdat),
		.ram_we_o    (ram_we),
		.ram_adr_o   (ram_adr),
		.ram_wdat_o  (ram_wdat),
		.core_dat_o  (core_dat_o),
		.core_rst_o  (core_rst_o),
		.load_done_o (load_done_o)
	);

	// video port bypasses the owner mux
	main_ram main_ram_i (
		.clk_32m    (clk_32m),
		.ram_we_i   (ram_we),
		.ram_adr_i  (ram_adr),
		.ram_wdat_i (ram_wdat),
		.vid_adr_i  (vid_adr_i),
		.ram_rdat_o (ram_rdat),
		.vid_dat_o  (vid_dat_o)
	);

endmodule

// ==== rtl/bbc_rom_boot_pkg.sv ====
package bbc_rom_boot_pkg;

	// cpu side address into the 64 KB main ram
	typedef logic [15:0] cpu_adr_t;

	// video fetch address, lower 32 KB only
	typedef logic [14:0] vid_adr_t;

	// one ram or flash data byte
	typedef logic [7:0] byte_t;

	// serial flash byte address, 24 bit addressing
	typedef logic [23:0] flash_adr_t;

	// standard slow read opcode
	localparam byte_t FLASH_READ_CMD = 8'h03;

	// rom image location in flash
	localparam flash_adr_t FLASH_BASE = 24'h008000;

	// image lands in the upper half of main ram
	localparam cpu_adr_t ROM_BASE = 16'h8000;

	// image size, 32 KB
	localparam int LOAD_BYTES = 32768;

	// loader fsm, one read transaction per reset
	typedef enum logic [2:0] {
		IDLE,
		CMD,
		ADDR,
		DATA,
		DONE
	} load_state_t;

endpackage

// ==== rtl/boot_control.sv ====
`timescale 1ns/100ps

module boot_control (
	input  logic                       clk_32m,
	input  logic                       rst_i,
	input  logic                       ld_active_i,
	input  logic                       ld_we_i,
	input  bbc_rom_boot_pkg::cpu_adr_t ld_adr_i,
	input  bbc_rom_boot_pkg::byte_t    ld_dat_i,
	input  bbc_rom_boot_pkg::cpu_adr_t core_adr_i,
	input  logic                       core_we_i,
	input  bbc_rom_boot_pkg::byte_t    core_dat_i,
	input  bbc_rom_boot_pkg::byte_t    ram_rdat_i,
	output logic                       ram_we_o,
	output bbc_rom_boot_pkg::cpu_adr_t ram_adr_o,
	output bbc_rom_boot_pkg::byte_t    ram_wdat_o,
	output bbc_rom_boot_pkg::byte_t    core_dat_o,
	output logic                       core_rst_o,
	output logic                       load_done_o
);

	logic ld_active_q;
	logic done_q;
	logic core_we_ok;

	// falling edge of ld_active marks the image complete
	always_ff @(posedge clk_32m) begin
		if (rst_i) begin
			ld_active_q <= 1'b0;
			done_q      <= 1'b0;
		end else begin
			ld_active_q <= ld_active_i;
			if (ld_active_q && !ld_active_i) begin
				done_q <= 1'b1;
			end
		end
	end

	// rom half is read only for the core
	assign core_we_ok = core_we_i && !core_adr_i[15];

	// loader owns port a until done, core writes dropped meanwhile
	assign ram_we_o   = done_q ? core_we_ok : ld_we_i;
	assign ram_adr_o  = done_q ? core_adr_i : ld_adr_i;
	assign ram_wdat_o = done_q ? core_dat_i : ld_dat_i;

	// read data goes straight back to the core
	assign core_dat_o = ram_rdat_i;

	// core held in reset until the image is in place
	assign core_rst_o  = !done_q;
	assign load_done_o = done_q;

endmodule

// ==== rtl/flash_loader.sv ====
`timescale 1ns/100ps

module flash_loader (
	input  logic                       clk_32m,
	input  logic                       rst_i,
	input  logic                       flash_miso_i,
	output logic                       flash_cs_o,
	output logic                       flash_sck_o,
	output logic                       flash_mosi_o,
	output logic                       ld_active_o,
	output logic                       ld_we_o,
	output bbc_rom_boot_pkg::cpu_adr_t ld_adr_o,
	output bbc_rom_boot_pkg::byte_t    ld_dat_o
);

	bbc_rom_boot_pkg::load_state_t state;

	// bits done in the current phase, max 24
	logic [4:0]  bit_cnt;
	// bytes written so far
	logic [15:0] byte_cnt;
	// cmd + address out, data in
	logic [31:0] shreg;

	logic last_byte;
	logic load_end;
	logic shifting;
	logic sck_rise;
	logic sck_fall;

	assign last_byte = (byte_cnt == 16'(bbc_rom_boot_pkg::LOAD_BYTES - 1));

	// strobe for the final byte ends the transaction
	assign load_end = ld_we_o && last_byte;

	// spi clock runs in cmd, addr and data phases
	assign shifting = ((state == bbc_rom_boot_pkg::CMD) ||
		(state == bbc_rom_boot_pkg::ADDR) ||
		(state == bbc_rom_boot_pkg::DATA)) && !load_end;

	// sck toggles every clk_32m cycle, so spi runs at 16 MHz
	assign sck_rise = shifting && !flash_sck_o;
	assign sck_fall = shifting && flash_sck_o;

	// write address follows the byte count
	assign ld_adr_o = bbc_rom_boot_pkg::ROM_BASE + byte_cnt;

	always_ff @(posedge clk_32m) begin
		if (rst_i) begin
			state       <= bbc_rom_boot_pkg::IDLE;
			flash_cs_o  <= 1'b1;
			flash_sck_o <= 1'b0;
			flash_mosi_o <= 1'b0;
			ld_active_o <= 1'b0;
			ld_we_o     <= 1'b0;
			bit_cnt     <= 5'd0;
			byte_cnt    <= 16'd0;
		end else begin
			ld_we_o <= 1'b0;

			// count once the byte has been written
			if (ld_we_o) begin
				byte_cnt <= byte_cnt + 16'd1;
			end

			if (state == bbc_rom_boot_pkg::IDLE) begin
				// open the read transaction straight out of reset
				state        <= bbc_rom_boot_pkg::CMD;
				flash_cs_o   <= 1'b0;
				ld_active_o  <= 1'b1;
				flash_mosi_o <= bbc_rom_boot_pkg::FLASH_READ_CMD[7];
			end else if (load_end) begin
				// deselect flash, never leave DONE until reset
				state       <= bbc_rom_boot_pkg::DONE;
				flash_cs_o  <= 1'b1;
				ld_active_o <= 1'b0;
			end else if (sck_rise) begin
				// flash samples mosi, we sample miso
				flash_sck_o <= 1'b1;
				bit_cnt     <= bit_cnt + 5'd1;
			end else if (sck_fall) begin
				flash_sck_o <= 1'b0;
				case (state)
					bbc_rom_boot_pkg::CMD: begin
						flash_mosi_o <= shreg[30];
						if (bit_cnt == 5'd8) begin
							state   <= bbc_rom_boot_pkg::ADDR;
							bit_cnt <= 5'd0;
						end
					end
					bbc_rom_boot_pkg::ADDR: begin
						flash_mosi_o <= shreg[30];
						if (bit_cnt == 5'd24) begin
							// mosi idles low during the data phase
							state        <= bbc_rom_boot_pkg::DATA;
							bit_cnt      <= 5'd0;
							flash_mosi_o <= 1'b0;
						end
					end
					bbc_rom_boot_pkg::DATA: begin
						// full byte in shreg, write it next cycle
						if (bit_cnt == 5'd8) begin
							ld_we_o <= 1'b1;
							bit_cnt <= 5'd0;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	// shift path, no reset needed
	always_ff @(posedge clk_32m) begin
		if (state == bbc_rom_boot_pkg::IDLE) begin
			shreg <= {bbc_rom_boot_pkg::FLASH_READ_CMD, bbc_rom_boot_pkg::FLASH_BASE};
		end else if (sck_rise && (state == bbc_rom_boot_pkg::DATA)) begin
			// msb first from the flash
			shreg <= {shreg[30:0], flash_miso_i};
		end else if (sck_fall && (state != bbc_rom_boot_pkg::DATA)) begin
			shreg <= {shreg[30:0], 1'b0};
		end

		// latch the byte with its write strobe
		if (sck_fall && (state == bbc_rom_boot_pkg::DATA) && (bit_cnt == 5'd8)) begin
			ld_dat_o <= shreg[7:0];
		end
	end

endmodule

// ==== rtl/main_ram.sv ====
`timescale 1ns/100ps

module main_ram (
	input  logic                       clk_32m,
	input  logic                       ram_we_i,
	input  bbc_rom_boot_pkg::cpu_adr_t ram_adr_i,
	input  bbc_rom_boot_pkg::byte_t    ram_wdat_i,
	input  bbc_rom_boot_pkg::vid_adr_t vid_adr_i,
	output bbc_rom_boot_pkg::byte_t    ram_rdat_o,
	output bbc_rom_boot_pkg::byte_t    vid_dat_o
);

	// 64 KB, lower half ram, upper half rom image
	bbc_rom_boot_pkg::byte_t mem [65536];

	// port a, read returns old data on a write cycle
	always_ff @(posedge clk_32m) begin
		if (ram_we_i) begin
			mem[ram_adr_i] <= ram_wdat_i;
		end
		ram_rdat_o <= mem[ram_adr_i];
	end

	// port b, video fetch from the lower 32 KB
	always_ff @(posedge clk_32m) begin
		vid_dat_o <= mem[{1'b0, vid_adr_i}];
	end

endmodule
